// ==== disk_macros.svh ====
`ifndef DISK_MACROS_SVH
`define DISK_MACROS_SVH

// Controller registers on the CPU bus
`define BK_ADDR_MODE     16'o177130
`define BK_ADDR_LBA      16'o177132

// Word in CPU memory that receives the error code
`define BK_ADDR_ERRCODE  16'o52

// Extended memory mode after reset
`define BK_MODE_RESET    16'o140

// One sector in 16-bit words
`define BK_SECTOR_WORDS  256

// First disk number that has no partition entry
`define BK_MAX_DISK      125

// Image header, "BKHD" in read order
`define BK_HDD_SIG       32'h424B4844
`define BK_HDD_VER       8'd1

`endif

// ==== bk_bus_pkg.sv ====
`default_nettype none

package bk_bus_pkg;

	typedef logic [15:0] bk_word_t;
	typedef logic [15:0] bk_addr_t;

	// Which controller register the bus cycle selects
	typedef enum logic [1:0] {
		sel_none,
		sel_mode,
		sel_lba
	} bk_sel_t;

	// Codes posted to the error word
	typedef enum logic [7:0] {
		err_ok      = 8'd0,
		err_range   = 8'd5,
		err_no_disk = 8'd6,
		err_param   = 8'd10
	} bk_err_t;

endpackage

`default_nettype wire

// ==== vhd_pkg.sv ====
`default_nettype none

package vhd_pkg;

	typedef logic [31:0] lba_t;
	typedef logic [7:0]  sector_idx_t;
	typedef logic [31:0] hdr_word_t;

	typedef enum logic {
		mem_read,
		mem_write
	} mem_op_t;

	typedef enum logic [4:0] {
		st_idle,
		// Parameter fetch
		st_par_r3,
		st_par_disk,
		st_par_r0,
		st_par_r1,
		st_par_r2,
		st_par_psw,
		st_par_err,
		st_check,
		// Disk read
		st_rd_sect,
		st_rd_wait,
		st_rd_fetch,
		st_rd_copy,
		st_rd_mem,
		// Disk write
		st_wr_sect,
		st_wr_mem,
		st_wr_store,
		st_wr_wait,
		// Result
		st_result,
		st_res_psw,
		st_res_end
	} io_state_t;

endpackage

`default_nettype wire

// ==== sector_ram.sv ====
`default_nettype none

module sector_ram #(
	parameter int words    = 256,
	parameter int wr_width = 16,
	parameter int rd_width = 16
) (
	input  logic                clk_sys,
	input  logic                wr_en,
	input  logic [$clog2((wr_width > rd_width) ? words : words * rd_width / wr_width)-1:0] wr_addr,
	input  logic [wr_width-1:0] wr_data,
	input  logic [$clog2((rd_width > wr_width) ? words : words * wr_width / rd_width)-1:0] rd_addr,
	output logic [rd_width-1:0] rd_data
);

	localparam int wide   = (wr_width > rd_width) ? wr_width : rd_width;
	localparam int narrow = (wr_width > rd_width) ? rd_width : wr_width;
	localparam int ratio  = wide / narrow;

	// Each entry is one word of the wide side
	logic [ratio-1:0][narrow-1:0] mem [words];

	generate
		if (wr_width > rd_width) begin : g_narrow_rd
			always_ff @(posedge clk_sys) begin
				if (wr_en) begin
					mem[wr_addr] <= wr_data;
				end
				rd_data <= mem[rd_addr / ratio][rd_addr % ratio];
			end
		end else begin : g_narrow_wr
			always_ff @(posedge clk_sys) begin
				if (wr_en) begin
					mem[wr_addr / ratio][wr_addr % ratio] <= wr_data;
				end
				rd_data <= mem[rd_addr];
			end
		end
	endgenerate

endmodule

`default_nettype wire

// ==== bus_regs.sv ====
`default_nettype none

`include "disk_macros.svh"

module bus_regs (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 disk_rom,
	input  logic [15:0]          bus_addr,
	input  logic [15:0]          bus_din,
	input  logic                 bus_sync,
	input  logic                 bus_we,
	input  logic [1:0]           bus_wtbt,
	input  logic                 bus_stb,
	output logic                 bus_ack,
	output bk_bus_pkg::bk_word_t ext_mode,
	output logic                 start,
	output bk_bus_pkg::bk_addr_t sp
);

	import bk_bus_pkg::*;

	bk_sel_t sel;
	logic    stb_d;
	logic    stb_rise;
	logic    armed;

	// Word address compare, byte bit ignored
	always_comb begin
		sel = sel_none;
		if (bus_sync && disk_rom) begin
			if ({bus_addr[15:1], 1'b0} == `BK_ADDR_MODE && bus_wtbt[0]) begin
				sel = sel_mode;
			end else if ({bus_addr[15:1], 1'b0} == `BK_ADDR_LBA && bus_we) begin
				sel = sel_lba;
			end
		end
	end

	assign bus_ack  = bus_sync & bus_stb & (sel != sel_none);
	assign stb_rise = bus_stb & ~stb_d;
	assign start    = stb_rise & (sel == sel_lba);
	assign sp       = bus_din;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			stb_d    <= 1'b0;
			armed    <= 1'b0;
			ext_mode <= `BK_MODE_RESET;
		end else begin
			stb_d <= bus_stb;
			if (stb_rise && sel == sel_mode && bus_we) begin
				ext_mode[3:2] <= bus_din[3:2];
				// A write of 6 unlocks the next write to the memory mode bits
				if (armed) begin
					ext_mode[6:4]  <= bus_din[6:4];
					ext_mode[11:8] <= {bus_din[0], bus_din[3], bus_din[2], bus_din[10]};
					armed          <= 1'b0;
				end else begin
					armed <= (bus_din == 16'o6);
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== mem_port.sv ====
`default_nettype none

module mem_port (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 req,
	input  vhd_pkg::mem_op_t     op,
	input  bk_bus_pkg::bk_addr_t addr,
	input  bk_bus_pkg::bk_word_t wdata,
	input  logic [15:0]          dsk_copy_din,
	output logic                 done,
	output bk_bus_pkg::bk_word_t rdata,
	output logic [24:0]          dsk_copy_addr,
	output logic [15:0]          dsk_copy_dout,
	output logic                 dsk_copy_rd,
	output logic                 dsk_copy_we
);

	import vhd_pkg::*;

	// 0 idle, 1 address, 2 and 3 strobe
	logic [1:0] step;
	mem_op_t    op_r;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			step        <= 2'd0;
			done        <= 1'b0;
			dsk_copy_rd <= 1'b0;
			dsk_copy_we <= 1'b0;
		end else begin
			done <= 1'b0;
			case (step)
				2'd0: begin
					if (req) begin
						step <= 2'd1;
					end
				end
				2'd1: begin
					dsk_copy_rd <= (op_r == mem_read);
					dsk_copy_we <= (op_r == mem_write);
					step        <= 2'd2;
				end
				2'd2: begin
					step <= 2'd3;
				end
				default: begin
					dsk_copy_rd <= 1'b0;
					dsk_copy_we <= 1'b0;
					done        <= 1'b1;
					step        <= 2'd0;
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (req && step == 2'd0) begin
			op_r          <= op;
			dsk_copy_addr <= {9'd0, addr};
			dsk_copy_dout <= wdata;
		end
		if (step == 2'd3) begin
			rdata <= dsk_copy_din;
		end
	end

endmodule

`default_nettype wire

// ==== sd_channel.sv ====
`default_nettype none

`include "disk_macros.svh"

module sd_channel (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   img_mounted,
	input  logic                   sd_ack,
	input  logic [7:0]             sd_buff_addr,
	input  logic [15:0]            sd_buff_dout,
	input  logic                   sd_buff_wr,
	input  logic                   rd_req,
	input  logic                   wr_req,
	input  vhd_pkg::lba_t          lba,
	input  logic [6:0]             hdr_index,
	input  vhd_pkg::sector_idx_t   buf_addr,
	input  logic [15:0]            buf_wdata,
	input  logic                   buf_we,
	output logic [31:0]            sd_lba,
	output logic                   sd_rd,
	output logic                   sd_wr,
	output logic [15:0]            sd_buff_din,
	output logic                   sd_busy,
	output logic                   mounted,
	output logic                   abort,
	output vhd_pkg::hdr_word_t     hdr_word,
	output logic [15:0]            buf_rdata
);

	logic        busy;
	logic        conf;
	logic        ack_d;
	logic        mnt_d;
	logic [31:0] hdd_sig;
	logic [7:0]  hdd_ver;

	assign sd_lba  = conf ? 32'd0 : lba;
	// A request counts as busy from the cycle it is raised
	assign sd_busy = busy | rd_req | wr_req;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			busy    <= 1'b0;
			conf    <= 1'b0;
			sd_rd   <= 1'b0;
			sd_wr   <= 1'b0;
			ack_d   <= 1'b0;
			mnt_d   <= 1'b0;
			mounted <= 1'b0;
			abort   <= 1'b0;
		end else begin
			abort <= 1'b0;
			ack_d <= sd_ack;
			if (ack_d && !sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
				busy  <= 1'b0;
				if (conf) begin
					mounted <= (hdd_sig == `BK_HDD_SIG) && (hdd_ver == `BK_HDD_VER);
					conf    <= 1'b0;
				end
			end
			if (!busy) begin
				mnt_d <= img_mounted;
				if (rd_req) begin
					sd_rd <= 1'b1;
					busy  <= 1'b1;
				end
				if (wr_req) begin
					sd_wr <= 1'b1;
					busy  <= 1'b1;
				end
				// New image, read its header from block 0
				if (img_mounted && !mnt_d) begin
					conf    <= 1'b1;
					mounted <= 1'b0;
					sd_rd   <= 1'b1;
					sd_wr   <= 1'b0;
					busy    <= 1'b1;
					abort   <= 1'b1;
				end
			end
		end
	end

	// Signature bytes arrive swapped within each word
	always_ff @(posedge clk_sys) begin
		if (conf && sd_ack && sd_buff_wr) begin
			case (sd_buff_addr)
				8'd0:    hdd_sig[31:16] <= {sd_buff_dout[7:0], sd_buff_dout[15:8]};
				8'd1:    hdd_sig[15:0]  <= {sd_buff_dout[7:0], sd_buff_dout[15:8]};
				8'd2:    hdd_ver        <= sd_buff_dout[7:0];
				default: ;
			endcase
		end
	end

	sector_ram #(.words(128), .wr_width(16), .rd_width(32)) hdr_ram (
		.clk_sys (clk_sys),
		.wr_en   (conf & sd_ack & sd_buff_wr),
		.wr_addr (sd_buff_addr),
		.wr_data (sd_buff_dout),
		.rd_addr (hdr_index),
		.rd_data (hdr_word)
	);

	sector_ram #(.words(256), .wr_width(16), .rd_width(16)) rd_ram (
		.clk_sys (clk_sys),
		.wr_en   (~conf & sd_ack & sd_buff_wr),
		.wr_addr (sd_buff_addr),
		.wr_data (sd_buff_dout),
		.rd_addr (buf_addr),
		.rd_data (buf_rdata)
	);

	sector_ram #(.words(256), .wr_width(16), .rd_width(16)) wr_ram (
		.clk_sys (clk_sys),
		.wr_en   (buf_we),
		.wr_addr (buf_addr),
		.wr_data (buf_wdata),
		.rd_addr (sd_buff_addr),
		.rd_data (sd_buff_din)
	);

endmodule

`default_nettype wire

// ==== io_sequencer.sv ====
`default_nettype none

`include "disk_macros.svh"

module io_sequencer (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 start,
	input  bk_bus_pkg::bk_addr_t sp,
	input  logic                 abort,
	input  logic                 done,
	input  bk_bus_pkg::bk_word_t rdata,
	input  logic                 sd_busy,
	input  logic                 mounted,
	input  vhd_pkg::hdr_word_t   hdr_word,
	input  logic [15:0]          buf_rdata,
	output logic                 busy,
	output logic                 req,
	output vhd_pkg::mem_op_t     op,
	output bk_bus_pkg::bk_addr_t addr,
	output bk_bus_pkg::bk_word_t wdata,
	output logic                 rd_req,
	output logic                 wr_req,
	output vhd_pkg::lba_t        lba,
	output logic [6:0]           hdr_index,
	output vhd_pkg::sector_idx_t buf_addr,
	output logic [15:0]          buf_wdata,
	output logic                 buf_we
);

	import bk_bus_pkg::*;
	import vhd_pkg::*;

	io_state_t state;
	bk_err_t   err_code;
	bk_addr_t  sp_r;
	bk_addr_t  vaddr;
	bk_word_t  psw;
	bk_word_t  err_word;
	hdr_word_t part_start;
	hdr_word_t part_end;
	logic [7:0]  disk;
	logic        is_write;
	logic [15:0] total;
	logic [8:0]  part;
	logic [8:0]  chunk;
	lba_t        last_blk;

	// Words moved with the next sector
	assign chunk = (total < 16'(`BK_SECTOR_WORDS)) ? total[8:0] : 9'(`BK_SECTOR_WORDS);
	// Block after the last one the request touches
	assign last_blk = lba + ((32'(total) + 32'(`BK_SECTOR_WORDS) - 32'd1) / 32'(`BK_SECTOR_WORDS));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= st_idle;
			busy   <= 1'b0;
			req    <= 1'b0;
			rd_req <= 1'b0;
			wr_req <= 1'b0;
			buf_we <= 1'b0;
		end else begin
			req    <= 1'b0;
			rd_req <= 1'b0;
			wr_req <= 1'b0;
			buf_we <= 1'b0;
			if (abort) begin
				busy  <= 1'b0;
				state <= st_idle;
			end else begin
				case (state)
					st_idle: begin
						if (start) begin
							busy  <= 1'b1;
							sp_r  <= sp;
							addr  <= sp + 16'd6;
							op    <= mem_read;
							req   <= 1'b1;
							state <= st_par_r3;
						end
					end
					// R3 points at the parameter block
					st_par_r3: begin
						if (done) begin
							addr  <= rdata + 16'o34;
							req   <= 1'b1;
							state <= st_par_disk;
						end
					end
					st_par_disk: begin
						if (done) begin
							disk      <= rdata[7:0];
							hdr_index <= rdata[6:0] + 7'd2;
							addr      <= sp_r;
							req       <= 1'b1;
							state     <= st_par_r0;
						end
					end
					st_par_r0: begin
						if (done) begin
							part_start <= hdr_word;
							lba        <= hdr_word + 32'(rdata);
							hdr_index  <= hdr_index + 7'd1;
							addr       <= sp_r + 16'd2;
							req        <= 1'b1;
							state      <= st_par_r1;
						end
					end
					// Negative length means write
					st_par_r1: begin
						if (done) begin
							is_write <= rdata[15];
							total    <= rdata[15] ? (~rdata + 16'd1) : rdata;
							addr     <= sp_r + 16'd4;
							req      <= 1'b1;
							state    <= st_par_r2;
						end
					end
					st_par_r2: begin
						if (done) begin
							part_end <= hdr_word;
							vaddr    <= rdata;
							addr     <= sp_r + 16'd8;
							req      <= 1'b1;
							state    <= st_par_psw;
						end
					end
					st_par_psw: begin
						if (done) begin
							psw   <= rdata;
							addr  <= `BK_ADDR_ERRCODE;
							req   <= 1'b1;
							state <= st_par_err;
						end
					end
					st_par_err: begin
						if (done) begin
							err_word <= rdata;
							state    <= st_check;
						end
					end
					st_check: begin
						if (!mounted || part_start == '0 || part_end == '0 || disk == 8'd0
							|| disk >= 8'(`BK_MAX_DISK)) begin
							err_code <= err_no_disk;
							state    <= st_result;
						end else if (total == 16'd0 || vaddr[0]) begin
							err_code <= err_param;
							state    <= st_result;
						end else if (last_blk > part_end) begin
							err_code <= err_range;
							state    <= st_result;
						end else if (is_write) begin
							state <= st_wr_sect;
						end else begin
							state <= st_rd_sect;
						end
					end
					st_rd_sect: begin
						if (!sd_busy) begin
							rd_req <= 1'b1;
							part   <= chunk;
							total  <= total - 16'(chunk);
							state  <= st_rd_wait;
						end
					end
					st_rd_wait: begin
						if (!sd_busy) begin
							buf_addr <= '0;
							state    <= st_rd_fetch;
						end
					end
					// Buffer read latency
					st_rd_fetch: begin
						state <= st_rd_copy;
					end
					st_rd_copy: begin
						addr  <= vaddr;
						wdata <= buf_rdata;
						op    <= mem_write;
						req   <= 1'b1;
						state <= st_rd_mem;
					end
					st_rd_mem: begin
						if (done) begin
							vaddr    <= vaddr + 16'd2;
							buf_addr <= buf_addr + 8'd1;
							part     <= part - 9'd1;
							if (part != 9'd1) begin
								state <= st_rd_fetch;
							end else if (total != 16'd0) begin
								lba   <= lba + 32'd1;
								state <= st_rd_sect;
							end else begin
								err_code <= err_ok;
								state    <= st_result;
							end
						end
					end
					st_wr_sect: begin
						part     <= chunk;
						total    <= total - 16'(chunk);
						buf_addr <= '0;
						addr     <= vaddr;
						op       <= mem_read;
						req      <= 1'b1;
						state    <= st_wr_mem;
					end
					st_wr_mem: begin
						if (done) begin
							buf_wdata <= rdata;
							buf_we    <= 1'b1;
							vaddr     <= vaddr + 16'd2;
							part      <= part - 9'd1;
							state     <= st_wr_store;
						end
					end
					st_wr_store: begin
						buf_addr <= buf_addr + 8'd1;
						if (part != 9'd0) begin
							addr  <= vaddr;
							req   <= 1'b1;
							state <= st_wr_mem;
						end else begin
							wr_req <= 1'b1;
							state  <= st_wr_wait;
						end
					end
					st_wr_wait: begin
						if (!sd_busy) begin
							if (total != 16'd0) begin
								lba   <= lba + 32'd1;
								state <= st_wr_sect;
							end else begin
								err_code <= err_ok;
								state    <= st_result;
							end
						end
					end
					// Error word keeps its high byte
					st_result: begin
						addr  <= `BK_ADDR_ERRCODE;
						wdata <= {err_word[15:8], err_code};
						op    <= mem_write;
						req   <= 1'b1;
						state <= st_res_psw;
					end
					// Carry flags the error to the caller
					st_res_psw: begin
						if (done) begin
							addr  <= sp_r + 16'd8;
							wdata <= {psw[15:1], err_code != err_ok};
							req   <= 1'b1;
							state <= st_res_end;
						end
					end
					st_res_end: begin
						if (done) begin
							busy  <= 1'b0;
							state <= st_idle;
						end
					end
					default: begin
						busy  <= 1'b0;
						state <= st_idle;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== disk_top.sv ====
`default_nettype none

module disk_top (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        disk_rom,
	output logic [15:0] ext_mode,

	input  logic [15:0] bus_din,
	input  logic [15:0] bus_addr,
	input  logic        bus_sync,
	input  logic        bus_we,
	input  logic [1:0]  bus_wtbt,
	input  logic        bus_stb,
	output logic        bus_ack,

	output logic        dsk_copy,
	output logic [24:0] dsk_copy_addr,
	input  logic [15:0] dsk_copy_din,
	output logic [15:0] dsk_copy_dout,
	output logic        dsk_copy_we,
	output logic        dsk_copy_rd,

	output logic [31:0] sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	input  logic        sd_ack,
	input  logic [7:0]  sd_buff_addr,
	input  logic [15:0] sd_buff_dout,
	output logic [15:0] sd_buff_din,
	input  logic        sd_buff_wr,

	input  logic        img_mounted
);

	import bk_bus_pkg::*;
	import vhd_pkg::*;

	logic        start;
	bk_addr_t    sp;
	logic        abort;
	logic        req;
	logic        done;
	mem_op_t     op;
	bk_addr_t    addr;
	bk_word_t    wdata;
	bk_word_t    rdata;
	logic        rd_req;
	logic        wr_req;
	logic        sd_busy;
	logic        mounted;
	lba_t        lba;
	logic [6:0]  hdr_index;
	hdr_word_t   hdr_word;
	sector_idx_t buf_addr;
	logic [15:0] buf_wdata;
	logic [15:0] buf_rdata;
	logic        buf_we;

	bus_regs regs0 (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.disk_rom (disk_rom),
		.bus_addr (bus_addr),
		.bus_din  (bus_din),
		.bus_sync (bus_sync),
		.bus_we   (bus_we),
		.bus_wtbt (bus_wtbt),
		.bus_stb  (bus_stb),
		.bus_ack  (bus_ack),
		.ext_mode (ext_mode),
		.start    (start),
		.sp       (sp)
	);

	mem_port port0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.req           (req),
		.op            (op),
		.addr          (addr),
		.wdata         (wdata),
		.dsk_copy_din  (dsk_copy_din),
		.done          (done),
		.rdata         (rdata),
		.dsk_copy_addr (dsk_copy_addr),
		.dsk_copy_dout (dsk_copy_dout),
		.dsk_copy_rd   (dsk_copy_rd),
		.dsk_copy_we   (dsk_copy_we)
	);

	sd_channel sd0 (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.img_mounted  (img_mounted),
		.sd_ack       (sd_ack),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.rd_req       (rd_req),
		.wr_req       (wr_req),
		.lba          (lba),
		.hdr_index    (hdr_index),
		.buf_addr     (buf_addr),
		.buf_wdata    (buf_wdata),
		.buf_we       (buf_we),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_buff_din  (sd_buff_din),
		.sd_busy      (sd_busy),
		.mounted      (mounted),
		.abort        (abort),
		.hdr_word     (hdr_word),
		.buf_rdata    (buf_rdata)
	);

	io_sequencer seq0 (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.start     (start),
		.sp        (sp),
		.abort     (abort),
		.done      (done),
		.rdata     (rdata),
		.sd_busy   (sd_busy),
		.mounted   (mounted),
		.hdr_word  (hdr_word),
		.buf_rdata (buf_rdata),
		.busy      (dsk_copy),
		.req       (req),
		.op        (op),
		.addr      (addr),
		.wdata     (wdata),
		.rd_req    (rd_req),
		.wr_req    (wr_req),
		.lba       (lba),
		.hdr_index (hdr_index),
		.buf_addr  (buf_addr),
		.buf_wdata (buf_wdata),
		.buf_we    (buf_we)
	);

endmodule

`default_nettype wire

// ==== tb_models.sv ====
`default_nettype none

module tb_models (
	input  logic        clk_sys,
	input  logic [24:0] dsk_copy_addr,
	input  logic [15:0] dsk_copy_dout,
	input  logic        dsk_copy_rd,
	input  logic        dsk_copy_we,
	output logic [15:0] dsk_copy_din,
	input  logic [31:0] sd_lba,
	input  logic        sd_rd,
	input  logic        sd_wr,
	output logic        sd_ack,
	output logic [7:0]  sd_buff_addr,
	output logic [15:0] sd_buff_dout,
	output logic        sd_buff_wr,
	input  logic [15:0] sd_buff_din
);

	// CPU memory as 32K words, SD card as 256 blocks of 256 words
	logic [15:0] mem [32768];
	logic [15:0] blk [256][256];
	logic [31:0] lba_log [16];
	int          lba_cnt = 0;
	int          seed;
	logic [15:0] rd_word = 16'd0;

	assign dsk_copy_din = rd_word;

	initial begin
		seed = 32'hf5670993;
		for (int i = 0; i < 32768; i++) begin
			mem[i] = 16'($random(seed));
		end
		for (int b = 0; b < 256; b++) begin
			for (int w = 0; w < 256; w++) begin
				blk[b][w] = {8'(b), 8'(w)};
			end
		end
		for (int w = 0; w < 256; w++) begin
			blk[0][w] = 16'd0;
		end
		// Header, bytes swapped per word, partition 1 is blocks 100 to 199
		blk[0][0] = 16'h4B42;
		blk[0][1] = 16'h4448;
		blk[0][2] = 16'h0001;
		blk[0][6] = 16'd100;
		blk[0][8] = 16'd199;
	end

	always @(posedge clk_sys) begin
		if (dsk_copy_rd) begin
			rd_word <= mem[dsk_copy_addr[15:1]];
		end
		if (dsk_copy_we) begin
			mem[dsk_copy_addr[15:1]] = dsk_copy_dout;
		end
	end

	initial begin
		int   b;
		logic is_rd;
		sd_ack       = 1'b0;
		sd_buff_addr = 8'd0;
		sd_buff_dout = 16'd0;
		sd_buff_wr   = 1'b0;
		forever begin
			@(posedge clk_sys);
			if (sd_rd || sd_wr) begin
				b     = int'(sd_lba[7:0]);
				is_rd = sd_rd;
				if (lba_cnt < 16) begin
					lba_log[lba_cnt] = sd_lba;
				end
				lba_cnt++;
				repeat (3) @(posedge clk_sys);
				sd_ack <= 1'b1;
				for (int i = 0; i < 256; i++) begin
					sd_buff_addr <= 8'(i);
					if (is_rd) begin
						sd_buff_dout <= blk[b][i];
						sd_buff_wr   <= 1'b1;
						@(posedge clk_sys);
					end else begin
						// Write buffer has one cycle of read latency
						@(posedge clk_sys);
						@(posedge clk_sys);
						blk[b][i] = sd_buff_din;
					end
				end
				sd_buff_wr <= 1'b0;
				sd_ack     <= 1'b0;
				@(posedge clk_sys);
				while (sd_rd || sd_wr) begin
					@(posedge clk_sys);
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_disk.sv ====
`default_nettype none

`include "disk_macros.svh"

module tb_disk;

	import bk_bus_pkg::*;
	import vhd_pkg::*;

	localparam int       max_rec    = 64;
	localparam int       part_first = 100;
	localparam bk_addr_t sp_addr    = 16'o1000;
	localparam bk_addr_t r3_addr    = 16'o2000;

	logic        clk_sys;
	logic        reset;
	logic        disk_rom;
	logic [15:0] ext_mode;
	logic [15:0] bus_din;
	logic [15:0] bus_addr;
	logic        bus_sync;
	logic        bus_we;
	logic [1:0]  bus_wtbt;
	logic        bus_stb;
	logic        bus_ack;
	logic        dsk_copy;
	logic [24:0] dsk_copy_addr;
	logic [15:0] dsk_copy_din;
	logic [15:0] dsk_copy_dout;
	logic        dsk_copy_we;
	logic        dsk_copy_rd;
	logic [31:0] sd_lba;
	logic        sd_rd;
	logic        sd_wr;
	logic        sd_ack;
	logic [7:0]  sd_buff_addr;
	logic [15:0] sd_buff_dout;
	logic [15:0] sd_buff_din;
	logic        sd_buff_wr;
	logic        img_mounted;

	logic [63:0] rec_kind [max_rec];
	logic [15:0] rec_disk [max_rec];
	logic [15:0] rec_r0   [max_rec];
	logic [15:0] rec_len  [max_rec];
	logic [15:0] rec_buf  [max_rec];
	logic [15:0] rec_exp  [max_rec];
	int          nrec = 0;
	bk_word_t    exp_data [512];

	disk_top dut0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.disk_rom      (disk_rom),
		.ext_mode      (ext_mode),
		.bus_din       (bus_din),
		.bus_addr      (bus_addr),
		.bus_sync      (bus_sync),
		.bus_we        (bus_we),
		.bus_wtbt      (bus_wtbt),
		.bus_stb       (bus_stb),
		.bus_ack       (bus_ack),
		.dsk_copy      (dsk_copy),
		.dsk_copy_addr (dsk_copy_addr),
		.dsk_copy_din  (dsk_copy_din),
		.dsk_copy_dout (dsk_copy_dout),
		.dsk_copy_we   (dsk_copy_we),
		.dsk_copy_rd   (dsk_copy_rd),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.sd_ack        (sd_ack),
		.sd_buff_addr  (sd_buff_addr),
		.sd_buff_dout  (sd_buff_dout),
		.sd_buff_din   (sd_buff_din),
		.sd_buff_wr    (sd_buff_wr),
		.img_mounted   (img_mounted)
	);

	tb_models models0 (
		.clk_sys       (clk_sys),
		.dsk_copy_addr (dsk_copy_addr),
		.dsk_copy_dout (dsk_copy_dout),
		.dsk_copy_rd   (dsk_copy_rd),
		.dsk_copy_we   (dsk_copy_we),
		.dsk_copy_din  (dsk_copy_din),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.sd_ack        (sd_ack),
		.sd_buff_addr  (sd_buff_addr),
		.sd_buff_dout  (sd_buff_dout),
		.sd_buff_wr    (sd_buff_wr),
		.sd_buff_din   (sd_buff_din)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#10 clk_sys = ~clk_sys;
		end
	end

	task automatic fail_run(input string why);
		$display("*** FAILED ***");
		$fatal(1, "%s", why);
	endtask

	task automatic check_word(input bk_word_t got, input bk_word_t exp, input string what);
		if (got !== exp) begin
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
			fail_run("word mismatch");
		end
	endtask

	task automatic check_err(input bk_err_t got, input bk_err_t exp);
		if (got !== exp) begin
			$display("error at %0t: error code is %0d, expected %0d", $time, got, exp);
			fail_run("error code mismatch");
		end
	endtask

	task automatic check_lba(input lba_t got, input lba_t exp);
		if (got !== exp) begin
			$display("error at %0t: sd_lba is %0d, expected %0d", $time, got, exp);
			fail_run("block number mismatch");
		end
	endtask

	task automatic bus_release();
		bus_sync <= 1'b0;
		bus_we   <= 1'b0;
		bus_wtbt <= 2'b00;
		bus_stb  <= 1'b0;
	endtask

	// One bus cycle, then compare the acknowledge
	task automatic probe_ack(input bk_addr_t a, input bk_word_t d, input logic rom,
		input logic we, input logic [1:0] wtbt, input logic exp);
		@(posedge clk_sys);
		disk_rom <= rom;
		bus_addr <= a;
		bus_din  <= d;
		bus_sync <= 1'b1;
		bus_we   <= we;
		bus_wtbt <= wtbt;
		bus_stb  <= 1'b1;
		@(posedge clk_sys);
		check_word({15'd0, bus_ack}, {15'd0, exp}, "bus_ack");
		bus_release();
		disk_rom <= 1'b1;
	endtask

	task automatic bus_write(input bk_addr_t a, input bk_word_t d);
		probe_ack(a, d, 1'b1, 1'b1, 2'b11, 1'b1);
	endtask

	task automatic mount_image(input logic bad);
		models0.blk[0][0] = bad ? 16'h0000 : 16'h4B42;
		models0.lba_cnt = 0;
		@(posedge clk_sys);
		img_mounted <= 1'b1;
		while (!sd_rd) begin
			@(posedge clk_sys);
		end
		img_mounted <= 1'b0;
		while (sd_rd) begin
			@(posedge clk_sys);
		end
		repeat (2) @(posedge clk_sys);
		check_word(16'(models0.lba_cnt), 16'd1, "mount SD requests");
		check_lba(models0.lba_log[0], 32'd0);
	endtask

	task automatic run_request(input int k);
		bk_word_t len;
		bk_word_t buf_a;
		bk_word_t neg;
		bk_word_t old_err;
		bk_word_t old_psw;
		bk_err_t  exp_err;
		logic     is_write;
		int       n;
		int       sectors;
		int       first;
		len      = rec_len[k];
		buf_a    = rec_buf[k];
		exp_err  = bk_err_t'(rec_exp[k][7:0]);
		is_write = len[15];
		neg      = ~len + 16'd1;
		n        = is_write ? int'(neg) : int'(len);
		sectors  = (n + 255) / 256;
		first    = part_first + int'(rec_r0[k]);
		models0.mem[int'(sp_addr >> 1)]     = rec_r0[k];
		models0.mem[int'(sp_addr >> 1) + 1] = len;
		models0.mem[int'(sp_addr >> 1) + 2] = buf_a;
		models0.mem[int'(sp_addr >> 1) + 3] = r3_addr;
		models0.mem[int'((r3_addr + 16'o34) >> 1)] = rec_disk[k];
		old_err = models0.mem[`BK_ADDR_ERRCODE >> 1];
		old_psw = models0.mem[int'(sp_addr >> 1) + 4];
		for (int i = 0; i < n && i < 512; i++) begin
			if (is_write) begin
				exp_data[i] = models0.mem[int'(buf_a >> 1) + i];
			end else begin
				exp_data[i] = models0.blk[(first + i / 256) % 256][i % 256];
			end
		end
		models0.lba_cnt = 0;
		bus_write(`BK_ADDR_LBA, sp_addr);
		while (!dsk_copy) begin
			@(posedge clk_sys);
		end
		while (dsk_copy) begin
			@(posedge clk_sys);
		end
		check_err(bk_err_t'(models0.mem[`BK_ADDR_ERRCODE >> 1][7:0]), exp_err);
		check_word({8'd0, models0.mem[`BK_ADDR_ERRCODE >> 1][15:8]}, {8'd0, old_err[15:8]},
			"error word high byte");
		check_word(models0.mem[int'(sp_addr >> 1) + 4], {old_psw[15:1], exp_err != err_ok}, "PSW");
		if (exp_err != err_ok) begin
			check_word(16'(models0.lba_cnt), 16'd0, "SD requests");
		end else begin
			check_word(16'(models0.lba_cnt), 16'(sectors), "SD requests");
			for (int s = 0; s < sectors; s++) begin
				check_lba(models0.lba_log[s], 32'(first + s));
			end
			for (int i = 0; i < n; i++) begin
				if (is_write) begin
					check_word(models0.blk[(first + i / 256) % 256][i % 256], exp_data[i],
						"SD block word");
				end else begin
					check_word(models0.mem[int'(buf_a >> 1) + i], exp_data[i], "memory word");
				end
			end
		end
	endtask

	task automatic read_records();
		int          fd;
		int          r;
		logic [63:0] kind;
		logic [8*128-1:0] rest;
		fd = $fopen("disk_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open disk_input.txt");
			fail_run("missing stimulus file");
		end
		while ($fscanf(fd, "%s", kind) == 1) begin
			if (kind == "#") begin
				r = $fgets(rest, fd);
			end else if (nrec < max_rec) begin
				r = $fscanf(fd, "%h %h %h %h %h", rec_disk[nrec], rec_r0[nrec], rec_len[nrec],
					rec_buf[nrec], rec_exp[nrec]);
				if (r != 5) begin
					$display("record %0d in disk_input.txt is incomplete", nrec);
					fail_run("malformed record");
				end
				rec_kind[nrec] = kind;
				nrec++;
			end
		end
		$fclose(fd);
	endtask

	// Watchdog
	initial begin
		wait (nrec > 0);
		#(longint'(nrec) * 200000);
		$display("timeout, the run did not finish within %0d records of time", nrec);
		fail_run("watchdog expired");
	end

	initial begin
		reset        = 1'b1;
		disk_rom     = 1'b1;
		bus_din      = 16'd0;
		bus_addr     = 16'd0;
		bus_sync     = 1'b0;
		bus_we       = 1'b0;
		bus_wtbt     = 2'b00;
		bus_stb      = 1'b0;
		img_mounted  = 1'b0;
		read_records();
		if (nrec == 0) begin
			$display("the stimulus file holds no records");
			fail_run("no records");
		end
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
		check_word(ext_mode, `BK_MODE_RESET, "ext_mode after reset");
		// Only kept registers with disk_rom high acknowledge
		probe_ack(`BK_ADDR_MODE, 16'd0, 1'b1, 1'b0, 2'b01, 1'b1);
		probe_ack(`BK_ADDR_MODE, 16'd0, 1'b0, 1'b0, 2'b01, 1'b0);
		probe_ack(`BK_ADDR_LBA, 16'd0, 1'b0, 1'b1, 2'b11, 1'b0);
		probe_ack(16'o177134, 16'd0, 1'b1, 1'b1, 2'b11, 1'b0);
		probe_ack(16'o177670, 16'd0, 1'b1, 1'b1, 2'b11, 1'b0);
		check_word(ext_mode, `BK_MODE_RESET, "ext_mode after probes");
		for (int k = 0; k < nrec; k++) begin
			if (rec_kind[k] == "mode") begin
				bus_write(`BK_ADDR_MODE, rec_buf[k]);
				@(posedge clk_sys);
				check_word(ext_mode, rec_exp[k], "ext_mode");
			end else if (rec_kind[k] == "mount") begin
				mount_image(rec_disk[k] != 16'd0);
			end else if (rec_kind[k] == "read" || rec_kind[k] == "write") begin
				run_request(k);
			end else begin
				$display("record %0d has an unknown kind", k);
				fail_run("bad record");
			end
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== disk_input.txt ====
# kind disk r0 length buffer expected, all hex
# mount uses disk 1 for a bad signature, mode uses buffer as the written data
mode  0 0 0    000c 006c
mode  0 0 0    0006 0064
mode  0 0 0    0459 0d58
mode  0 0 0    0006 0d54
mode  0 0 0    0000 0000
read  1 0 4    1000 6
mount 0 0 0    0000 0
read  1 0 5    1000 0
read  1 3 0120 1000 0
write 1 5 fffd 2000 0
write 1 7 fe00 2000 0
read  1 7 0200 3000 0
read  1 0 0    1000 a
read  1 0 4    1001 a
read  1 62 0100 1000 0
read  1 63 0100 1000 5
write 1 62 fe00 2000 5
read  0 0 4    1000 6
mount 1 0 0    0000 0
read  1 0 4    1000 6
mount 0 0 0    0000 0
read  1 0 4    1000 0

// ==== sim.f ====
+incdir+.
bk_bus_pkg.sv
vhd_pkg.sv
sector_ram.sv
bus_regs.sv
mem_port.sv
sd_channel.sv
io_sequencer.sv
disk_top.sv
tb_models.sv
tb_disk.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat sim.f)) disk_macros.svh

all: run

obj_dir/Vtb_disk: sim.f $(SRCS)
	verilator --binary --timing -f sim.f --top-module tb_disk -o Vtb_disk

run: obj_dir/Vtb_disk
	./obj_dir/Vtb_disk > sim.log 2>&1 || true
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
